// File: design/router_pkg.sv
// ==============================
// shared widths, port directions and flit layout for the VC router
// import with router_pkg::* in the module or interface header
// ==============================

`default_nettype none

package router_pkg;

  // ==============================
  // router geometry
  // ==============================

  // five physical ports, each with two virtual channels
  localparam int NUM_PORTS = 5;
  localparam int NUM_VC = 2;
  localparam int VC_W = 1;

  // width of a port index, also the width of the direction enum
  localparam int PORT_IDX_W = 3;

  // mesh coordinates and payload
  localparam int COORD_W = 3;
  localparam int PAYLOAD_W = 16;

  // port directions, used as array index and as route result
  typedef enum logic [PORT_IDX_W-1:0] {
    PORT_N = 3'd0,
    PORT_E = 3'd1,
    PORT_S = 3'd2,
    PORT_W = 3'd3,
    PORT_L = 3'd4
  } port_e;

  // ==============================
  // flit format
  // ==============================

  // single-flit packet, 23 bits
  // vc_id is the VC this flit occupies in the receiving router
  typedef struct packed {
    logic [COORD_W-1:0]   dst_x;
    logic [COORD_W-1:0]   dst_y;
    logic [VC_W-1:0]      vc_id;
    logic [PAYLOAD_W-1:0] payload;
  } flit_t;

endpackage

`default_nettype wire

// File: design/sa_if.sv
// ==============================
// switch allocation handshake between one input port and the allocator
// input port requests per VC, allocator answers with a one-cycle grant
// ==============================

`timescale 1ns/1ps
`default_nettype none

interface sa_if import router_pkg::*; ();

  // head of each non-empty VC and its XY route
  logic [NUM_VC-1:0] req_v;
  port_e             req_dir [NUM_VC];

  // grant pulse, granted VC and the downstream VC to stamp
  logic              grant_v;
  logic [VC_W-1:0]   grant_vc;
  logic [VC_W-1:0]   grant_out_vc;

  modport port (output req_v, output req_dir,
                input grant_v, input grant_vc, input grant_out_vc);

  modport alloc (input req_v, input req_dir,
                 output grant_v, output grant_vc, output grant_out_vc);

endinterface

`default_nettype wire

// File: design/credit_if.sv
// ==============================
// downstream VC availability for one output port
// credit block offers a free VC, allocator consumes one credit per grant
// ==============================

`timescale 1ns/1ps
`default_nettype none

interface credit_if import router_pkg::*; ();

  // some downstream VC holds a credit
  logic            avail;
  // lowest-index VC with a credit
  logic [VC_W-1:0] sel_vc;
  // take one credit from sel_vc this cycle
  logic            consume_v;

  modport alloc (input avail, input sel_vc, output consume_v);

  modport credits (output avail, output sel_vc, input consume_v);

endinterface

`default_nettype wire

// File: design/vc_input_port.sv
// ==============================
// one router input: a circular FIFO per VC, XY routing of each head,
// pop on grant and credit return to the upstream router
// ==============================

`timescale 1ns/1ps
`default_nettype none

module vc_input_port import router_pkg::*; #(
  parameter int VC_DEPTH = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               data_v_i,
  input  flit_t              data_i,
  input  logic [COORD_W-1:0] xy_x_i,
  input  logic [COORD_W-1:0] xy_y_i,
  sa_if.port                 sa,
  output flit_t              pop_flit_o,
  output logic               credit_v_o,
  output logic [VC_W-1:0]    credit_id_o
);

  localparam int PTR_W = (VC_DEPTH > 1) ? $clog2(VC_DEPTH) : 1;
  localparam int CNT_W = $clog2(VC_DEPTH + 1);

  flit_t                        mem_q [NUM_VC][VC_DEPTH];
  logic [NUM_VC-1:0][PTR_W-1:0] wr_ptr_q;
  logic [NUM_VC-1:0][PTR_W-1:0] rd_ptr_q;
  logic [NUM_VC-1:0][CNT_W-1:0] cnt_q;
  logic [NUM_VC-1:0]            push;
  logic [NUM_VC-1:0]            pop;
  flit_t                        head [NUM_VC];
  flit_t                        pop_flit_d;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(VC_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // dimension-order routing, x first
  function automatic port_e xy_route(input flit_t f, input logic [COORD_W-1:0] x,
                                     input logic [COORD_W-1:0] y);
    if (f.dst_x > x) return PORT_E;
    if (f.dst_x < x) return PORT_W;
    if (f.dst_y > y) return PORT_N;
    if (f.dst_y < y) return PORT_S;
    return PORT_L;
  endfunction

  for (genvar v = 0; v < NUM_VC; v++) begin : gen_vc
    assign push[v] = data_v_i && (data_i.vc_id == VC_W'(v));
    assign pop[v]  = sa.grant_v && (sa.grant_vc == VC_W'(v));
    assign head[v] = mem_q[v][rd_ptr_q[v]];

    assign sa.req_v[v]   = (cnt_q[v] != '0);
    assign sa.req_dir[v] = xy_route(head[v], xy_x_i, xy_y_i);
  end

  // flit storage
  always_ff @(posedge clk_i) begin
    for (int v = 0; v < NUM_VC; v++) begin
      if (push[v]) begin
        mem_q[v][wr_ptr_q[v]] <= data_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      for (int v = 0; v < NUM_VC; v++) begin
        if (push[v]) wr_ptr_q[v] <= ptr_next(wr_ptr_q[v]);
        if (pop[v]) rd_ptr_q[v] <= ptr_next(rd_ptr_q[v]);
        // simultaneous push and pop keeps the count
        if (push[v] && !pop[v]) cnt_q[v] <= cnt_q[v] + 1'b1;
        else if (pop[v] && !push[v]) cnt_q[v] <= cnt_q[v] - 1'b1;
      end
    end
  end

  // granted head leaves with its downstream VC already stamped
  always_comb begin
    pop_flit_d       = head[sa.grant_vc];
    pop_flit_d.vc_id = sa.grant_out_vc;
  end

  always_ff @(posedge clk_i) begin
    if (sa.grant_v) pop_flit_o <= pop_flit_d;
  end

  // one credit per popped flit, back to the upstream router
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      credit_v_o  <= 1'b0;
      credit_id_o <= '0;
    end else begin
      credit_v_o  <= sa.grant_v;
      credit_id_o <= sa.grant_vc;
    end
  end

endmodule

`default_nettype wire

// File: design/switch_allocator.sv
// ==============================
// two-step round-robin switch allocation: one VC per input, then one
// input per output; only outputs with a free downstream VC take part
// ==============================

`timescale 1ns/1ps
`default_nettype none

module switch_allocator import router_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  sa_if.alloc                                 sa [NUM_PORTS],
  credit_if.alloc                             cr [NUM_PORTS],
  output logic [NUM_PORTS-1:0]                st_v_o,
  output logic [NUM_PORTS-1:0][NUM_PORTS-1:0] st_in_sel_o,
  output logic [NUM_PORTS-1:0][VC_W-1:0]      st_out_vc_o
);

  logic [NUM_PORTS-1:0][NUM_VC-1:0]     req_v;
  port_e                                req_dir [NUM_PORTS][NUM_VC];
  logic [NUM_PORTS-1:0]                 avail;
  logic [NUM_PORTS-1:0][VC_W-1:0]       sel_vc;
  logic [NUM_PORTS-1:0][VC_W-1:0]       lrr_ptr_q;
  logic [NUM_PORTS-1:0][PORT_IDX_W-1:0] grr_ptr_q;
  logic [NUM_PORTS-1:0]                 lw_v;
  logic [NUM_PORTS-1:0][VC_W-1:0]       lw_vc;
  port_e                                lw_dir [NUM_PORTS];
  logic [NUM_PORTS-1:0]                 gw_v;
  logic [NUM_PORTS-1:0][PORT_IDX_W-1:0] gw_in;
  logic [NUM_PORTS-1:0]                 in_grant;
  logic [NUM_PORTS-1:0][VC_W-1:0]       in_out_vc;

  // flatten the interface arrays
  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_if
    assign req_v[p]   = sa[p].req_v;
    assign req_dir[p] = sa[p].req_dir;
    assign avail[p]   = cr[p].avail;
    assign sel_vc[p]  = cr[p].sel_vc;

    assign sa[p].grant_v      = in_grant[p];
    assign sa[p].grant_vc     = lw_vc[p];
    assign sa[p].grant_out_vc = in_out_vc[p];
    assign cr[p].consume_v    = gw_v[p];
  end

  // ==============================
  // local stage, per input
  // ==============================

  always_comb begin
    int idx;
    for (int i = 0; i < NUM_PORTS; i++) begin
      lw_v[i]   = 1'b0;
      lw_vc[i]  = '0;
      lw_dir[i] = PORT_L;
      // first eligible VC at or after the pointer
      for (int k = 0; k < NUM_VC; k++) begin
        idx = (int'(lrr_ptr_q[i]) + k) % NUM_VC;
        if (!lw_v[i] && req_v[i][idx] && avail[req_dir[i][idx]]) begin
          lw_v[i]   = 1'b1;
          lw_vc[i]  = VC_W'(idx);
          lw_dir[i] = req_dir[i][idx];
        end
      end
    end
  end

  // ==============================
  // global stage, per output
  // ==============================

  always_comb begin
    int idx;
    for (int o = 0; o < NUM_PORTS; o++) begin
      gw_v[o]  = 1'b0;
      gw_in[o] = '0;
      for (int k = 0; k < NUM_PORTS; k++) begin
        idx = (int'(grr_ptr_q[o]) + k) % NUM_PORTS;
        if (!gw_v[o] && lw_v[idx] && (lw_dir[idx] == port_e'(o))) begin
          gw_v[o]  = 1'b1;
          gw_in[o] = PORT_IDX_W'(idx);
        end
      end
    end
  end

  // map winners back to their inputs
  always_comb begin
    in_grant    = '0;
    in_out_vc   = '0;
    st_in_sel_o = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (gw_v[o]) begin
        in_grant[gw_in[o]]        = 1'b1;
        in_out_vc[gw_in[o]]       = sel_vc[o];
        st_in_sel_o[o][gw_in[o]]  = 1'b1;
      end
    end
  end

  assign st_v_o      = gw_v;
  assign st_out_vc_o = sel_vc;

  // pointers move past the winners; a local loser keeps its turn
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lrr_ptr_q <= '0;
      grr_ptr_q <= '0;
    end else begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (in_grant[p]) begin
          lrr_ptr_q[p] <= (lw_vc[p] == VC_W'(NUM_VC - 1)) ? '0 : lw_vc[p] + 1'b1;
        end
        if (gw_v[p]) begin
          grr_ptr_q[p] <= (gw_in[p] == PORT_IDX_W'(NUM_PORTS - 1)) ? '0 : gw_in[p] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/output_vc_credits.sv
// ==============================
// credit counters for every downstream VC of every output
// offers the lowest VC that still holds a credit to the allocator
// ==============================

`timescale 1ns/1ps
`default_nettype none

module output_vc_credits import router_pkg::*; #(
  parameter int VC_DEPTH = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [NUM_PORTS-1:0]           credit_v_i,
  input  logic [NUM_PORTS-1:0][VC_W-1:0] credit_id_i,
  credit_if.credits                      cr [NUM_PORTS]
);

  localparam int CNT_W = $clog2(VC_DEPTH + 1);

  logic [NUM_PORTS-1:0][NUM_VC-1:0][CNT_W-1:0] cnt_q;
  logic [NUM_PORTS-1:0][NUM_VC-1:0]            has_credit;
  logic [NUM_PORTS-1:0][NUM_VC-1:0]            cnt_inc;
  logic [NUM_PORTS-1:0][NUM_VC-1:0]            cnt_dec;
  logic [NUM_PORTS-1:0][VC_W-1:0]              sel_vc;
  logic [NUM_PORTS-1:0]                        consume;

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_if
    assign consume[o]   = cr[o].consume_v;
    assign cr[o].avail  = |has_credit[o];
    assign cr[o].sel_vc = sel_vc[o];
  end

  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      sel_vc[o] = '0;
      // walk downwards so the lowest free VC is kept
      for (int v = NUM_VC - 1; v >= 0; v--) begin
        has_credit[o][v] = (cnt_q[o][v] != '0);
        if (has_credit[o][v]) sel_vc[o] = VC_W'(v);
      end
      // only the final selection may lose a credit
      for (int v = 0; v < NUM_VC; v++) begin
        cnt_inc[o][v] = credit_v_i[o] && (credit_id_i[o] == VC_W'(v));
        cnt_dec[o][v] = consume[o] && (sel_vc[o] == VC_W'(v)) && has_credit[o][v];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        for (int v = 0; v < NUM_VC; v++) begin
          cnt_q[o][v] <= CNT_W'(VC_DEPTH);
        end
      end
    end else begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        for (int v = 0; v < NUM_VC; v++) begin
          // returned and consumed together cancel out
          if (cnt_inc[o][v] && !cnt_dec[o][v] && (cnt_q[o][v] < CNT_W'(VC_DEPTH))) begin
            cnt_q[o][v] <= cnt_q[o][v] + 1'b1;
          end else if (cnt_dec[o][v] && !cnt_inc[o][v]) begin
            cnt_q[o][v] <= cnt_q[o][v] - 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/switch_traversal.sv
// ==============================
// stage register between allocation and traversal, then the crossbar
// each output takes the popped flit of its selected input
// ==============================

`timescale 1ns/1ps
`default_nettype none

module switch_traversal import router_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic [NUM_PORTS-1:0]                st_v_i,
  input  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] st_in_sel_i,
  input  logic [NUM_PORTS-1:0][VC_W-1:0]      st_out_vc_i,
  input  flit_t [NUM_PORTS-1:0]               pop_flit_i,
  output logic [NUM_PORTS-1:0]                data_v_o,
  output flit_t [NUM_PORTS-1:0]               data_o
);

  logic [NUM_PORTS-1:0]                st_v_q;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0] st_in_sel_q;
  logic [NUM_PORTS-1:0][VC_W-1:0]      st_out_vc_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      st_v_q      <= '0;
      st_in_sel_q <= '0;
    end else begin
      st_v_q      <= st_v_i;
      st_in_sel_q <= st_in_sel_i;
    end
  end

  always_ff @(posedge clk_i) begin
    st_out_vc_q <= st_out_vc_i;
  end

  // ==============================
  // crossbar
  // ==============================

  always_comb begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      data_o[o] = '0;
      // select is one-hot per output
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (st_in_sel_q[o][i]) data_o[o] = pop_flit_i[i];
      end
      data_o[o].vc_id = st_out_vc_q[o];
    end
  end

  assign data_v_o = st_v_q;

endmodule

`default_nettype wire

// File: design/vc_router.sv
// ==============================
// five-port mesh router with two VCs per port and credit flow control
// set VC_DEPTH to the FIFO depth of the neighbouring routers
// ==============================

`timescale 1ns/1ps
`default_nettype none

module vc_router import router_pkg::*; #(
  parameter int VC_DEPTH = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [COORD_W-1:0]             xy_x_i,
  input  logic [COORD_W-1:0]             xy_y_i,
  // from upstream routers
  input  logic [NUM_PORTS-1:0]           data_v_i,
  input  flit_t [NUM_PORTS-1:0]          data_i,
  output logic [NUM_PORTS-1:0]           credit_v_o,
  output logic [NUM_PORTS-1:0][VC_W-1:0] credit_id_o,
  // to downstream routers
  output logic [NUM_PORTS-1:0]           data_v_o,
  output flit_t [NUM_PORTS-1:0]          data_o,
  input  logic [NUM_PORTS-1:0]           credit_v_i,
  input  logic [NUM_PORTS-1:0][VC_W-1:0] credit_id_i
);

  sa_if     u_sa [NUM_PORTS] ();
  credit_if u_cr [NUM_PORTS] ();

  flit_t [NUM_PORTS-1:0]                pop_flit;
  logic [NUM_PORTS-1:0]                 st_v;
  logic [NUM_PORTS-1:0][NUM_PORTS-1:0]  st_in_sel;
  logic [NUM_PORTS-1:0][VC_W-1:0]       st_out_vc;

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_in
    vc_input_port #(
      .VC_DEPTH (VC_DEPTH)
    ) u_in (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .data_v_i    (data_v_i[p]),
      .data_i      (data_i[p]),
      .xy_x_i      (xy_x_i),
      .xy_y_i      (xy_y_i),
      .sa          (u_sa[p]),
      .pop_flit_o  (pop_flit[p]),
      .credit_v_o  (credit_v_o[p]),
      .credit_id_o (credit_id_o[p])
    );
  end

  switch_allocator u_alloc (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .sa          (u_sa),
    .cr          (u_cr),
    .st_v_o      (st_v),
    .st_in_sel_o (st_in_sel),
    .st_out_vc_o (st_out_vc)
  );

  output_vc_credits #(
    .VC_DEPTH (VC_DEPTH)
  ) u_credits (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .credit_v_i  (credit_v_i),
    .credit_id_i (credit_id_i),
    .cr          (u_cr)
  );

  switch_traversal u_st (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .st_v_i      (st_v),
    .st_in_sel_i (st_in_sel),
    .st_out_vc_i (st_out_vc),
    .pop_flit_i  (pop_flit),
    .data_v_o    (data_v_o),
    .data_o      (data_o)
  );

endmodule

`default_nettype wire

// File: bench/tb_vc_router.sv
// ==============================
// self-checking testbench for the VC router placed at mesh node (2,2)
// emulates upstream senders and downstream routers that return credits
// run with the Makefile, which searches the log for the result
// ==============================

`timescale 1ns/1ps
`default_nettype none

module tb_vc_router import router_pkg::*; ();

  localparam int VC_DEPTH = 2;
  localparam int MY_X = 2;
  localparam int MY_Y = 2;
  localparam int FLOOD_N = 6;

  logic                           clk = 1'b0;
  logic                           rst_n;
  logic [NUM_PORTS-1:0]           in_v;
  flit_t [NUM_PORTS-1:0]          in_flit;
  logic [NUM_PORTS-1:0]           up_cr_v;
  logic [NUM_PORTS-1:0][VC_W-1:0] up_cr_id;
  logic [NUM_PORTS-1:0]           out_v;
  flit_t [NUM_PORTS-1:0]          out_flit;
  logic [NUM_PORTS-1:0]           dn_cr_v;
  logic [NUM_PORTS-1:0][VC_W-1:0] dn_cr_id;

  // scoreboard state
  flit_t           tx_q [NUM_PORTS][$];
  flit_t           exp_q [NUM_PORTS][$];
  logic [VC_W-1:0] ret_q [NUM_PORTS][$];
  int              up_cred [NUM_PORTS][NUM_VC];
  int              inflight [NUM_PORTS][NUM_VC];
  int              ds_cred [NUM_PORTS][NUM_VC];
  int              ret_wait [NUM_PORTS];
  int              rx_cnt [NUM_PORTS];
  int              src_cnt [NUM_PORTS];
  logic            hold_east;
  logic            flooding;
  logic [31:0]     lcg_state = 32'h685a;
  int              seq;
  int              err_cnt;
  int              timeout_cnt;
  int              east_base;
  string           test_name;

  vc_router #(
    .VC_DEPTH (VC_DEPTH)
  ) u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .xy_x_i      (COORD_W'(MY_X)),
    .xy_y_i      (COORD_W'(MY_Y)),
    .data_v_i    (in_v),
    .data_i      (in_flit),
    .credit_v_o  (up_cr_v),
    .credit_id_o (up_cr_id),
    .data_v_o    (out_v),
    .data_o      (out_flit),
    .credit_v_i  (dn_cr_v),
    .credit_id_i (dn_cr_id)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 16;
  endfunction

  // expected output port, x first then y
  function automatic port_e route_of(input int x, input int y);
    if (x > MY_X) return PORT_E;
    if (x < MY_X) return PORT_W;
    if (y > MY_Y) return PORT_N;
    if (y < MY_Y) return PORT_S;
    return PORT_L;
  endfunction

  function automatic bit drained();
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (tx_q[p].size() != 0 || exp_q[p].size() != 0 || ret_q[p].size() != 0) return 1'b0;
      for (int v = 0; v < NUM_VC; v++) begin
        if (inflight[p][v] != 0) return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // payload carries the source port and a running number
  task automatic queue_flit(input int src, input int x, input int y);
    flit_t f;
    f.dst_x   = COORD_W'(x);
    f.dst_y   = COORD_W'(y);
    f.vc_id   = '0;
    f.payload = {PORT_IDX_W'(src), 13'(seq)};
    seq++;
    tx_q[src].push_back(f);
  endtask

  // destinations that a flit entering on src may legally have
  task automatic queue_random(input int src);
    int x;
    int y;
    x = int'(next_rand() % 8);
    y = int'(next_rand() % 8);
    case (src)
      PORT_N: begin
        x = MY_X;
        y = int'(next_rand() % (MY_Y + 1));
      end
      PORT_S: begin
        x = MY_X;
        y = MY_Y + int'(next_rand() % (8 - MY_Y));
      end
      PORT_E: x = int'(next_rand() % (MY_X + 1));
      PORT_W: x = MY_X + int'(next_rand() % (8 - MY_X));
      default: ;
    endcase
    queue_flit(src, x, y);
  endtask

  task automatic send_head(input int p);
    flit_t f;
    int v;
    if (tx_q[p].size() == 0) return;
    v = int'(next_rand() % NUM_VC);
    if (up_cred[p][v] == 0) v = NUM_VC - 1 - v;
    if (up_cred[p][v] == 0) return;
    f = tx_q[p].pop_front();
    f.vc_id = VC_W'(v);
    up_cred[p][v]--;
    inflight[p][v]++;
    exp_q[route_of(f.dst_x, f.dst_y)].push_back(f);
    in_v[p]    = 1'b1;
    in_flit[p] = f;
  endtask

  // downstream router frees a slot after a random pause
  task automatic return_credit(input int o);
    if (ret_wait[o] > 0) begin
      ret_wait[o]--;
      return;
    end
    if (ret_q[o].size() == 0 || (hold_east && o == PORT_E)) return;
    dn_cr_id[o] = ret_q[o].pop_front();
    dn_cr_v[o]  = 1'b1;
    ds_cred[o][dn_cr_id[o]]++;
    ret_wait[o] = int'(next_rand() % 4);
  endtask

  always @(posedge clk) begin
    #1;
    in_v    = '0;
    dn_cr_v = '0;
    if (rst_n) begin
      for (int p = 0; p < NUM_PORTS; p++) send_head(p);
      for (int o = 0; o < NUM_PORTS; o++) return_credit(o);
    end
  end

  // ==============================
  // compare
  // ==============================

  task automatic check_output(input int o, input flit_t f);
    int    idx;
    int    src;
    flit_t e;
    idx = -1;
    for (int k = 0; k < exp_q[o].size(); k++) begin
      e = exp_q[o][k];
      if (idx < 0 && e.payload == f.payload) idx = k;
    end
    assert (idx >= 0) else begin
      err_cnt++;
      $display("** Error %s: output %0d expected no flit, actual payload %h",
               test_name, o, f.payload);
    end
    if (idx >= 0) begin
      e = exp_q[o][idx];
      exp_q[o].delete(idx);
      assert (f.dst_x == e.dst_x && f.dst_y == e.dst_y) else begin
        err_cnt++;
        $display("** Error %s: output %0d dst expected (%0d,%0d), actual (%0d,%0d)",
                 test_name, o, e.dst_x, e.dst_y, f.dst_x, f.dst_y);
      end
    end
    assert (ds_cred[o][f.vc_id] > 0) else begin
      err_cnt++;
      $display("** Error %s: output %0d vc %0d credits expected > 0, actual %0d",
               test_name, o, f.vc_id, ds_cred[o][f.vc_id]);
    end
    ds_cred[o][f.vc_id]--;
    ret_q[o].push_back(f.vc_id);
    rx_cnt[o]++;
    if (flooding) begin
      src = int'(f.payload[PAYLOAD_W-1 -: PORT_IDX_W]);
      src_cnt[src]++;
      // every other flooding input got through before this one is done
      if (src_cnt[src] == FLOOD_N) begin
        for (int s = PORT_N; s <= PORT_W; s++) begin
          assert (s == src || src_cnt[s] > 0) else begin
            err_cnt++;
            $display("** Error %s: input %0d flits expected > 0 when input %0d done, actual 0",
                     test_name, s, src);
          end
        end
      end
    end
  endtask

  task automatic check_credit(input int p, input logic [VC_W-1:0] v);
    assert (inflight[p][v] > 0) else begin
      err_cnt++;
      $display("** Error %s: input %0d credit_id expected a VC holding a flit, actual %0d",
               test_name, p, v);
    end
    if (inflight[p][v] > 0) begin
      inflight[p][v]--;
      up_cred[p][v]++;
    end
  endtask

  always @(negedge clk) begin
    if (rst_n) begin
      for (int o = 0; o < NUM_PORTS; o++) begin
        if (out_v[o]) check_output(o, out_flit[o]);
      end
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (up_cr_v[p]) check_credit(p, up_cr_id[p]);
      end
    end
  end

  // ==============================
  // run control
  // ==============================

  task automatic report_and_finish();
    $display("errors: %0d check failures, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  endtask

  task automatic note_timeout(input string what);
    timeout_cnt++;
    $display("timeout in %s while waiting for %s", test_name, what);
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while (!drained() && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!drained()) begin
      note_timeout("all flits and credits to come back");
    end
    // last credit_v_i still has to reach the counters
    repeat (3) @(posedge clk);
  endtask

  task automatic wait_east(input int count, input int limit);
    int n;
    n = 0;
    while (rx_cnt[PORT_E] < count && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (rx_cnt[PORT_E] < count) begin
      note_timeout("flits on the East output");
    end
  endtask

  initial begin
    in_v        = '0;
    in_flit     = '0;
    dn_cr_v     = '0;
    dn_cr_id    = '0;
    rst_n       = 1'b0;
    hold_east   = 1'b0;
    flooding    = 1'b0;
    seq         = 0;
    err_cnt     = 0;
    timeout_cnt = 0;
    test_name   = "reset";
    for (int p = 0; p < NUM_PORTS; p++) begin
      ret_wait[p] = 0;
      rx_cnt[p]   = 0;
      src_cnt[p]  = 0;
      for (int v = 0; v < NUM_VC; v++) begin
        up_cred[p][v]  = VC_DEPTH;
        ds_cred[p][v]  = VC_DEPTH;
        inflight[p][v] = 0;
      end
    end
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;

    test_name = "reset_idle";
    repeat (10) begin
      @(negedge clk);
      assert (out_v == '0 && up_cr_v == '0) else begin
        err_cnt++;
        $display("** Error %s: data_v_o/credit_v_o expected 0/0, actual %b/%b",
                 test_name, out_v, up_cr_v);
      end
    end
    test_name = "single_flit";
    queue_flit(PORT_W, MY_X, MY_Y);
    wait_drain(100);

    if (timeout_cnt == 0) begin
      test_name = "xy_routing";
      repeat (60) queue_random(int'(next_rand() % NUM_PORTS));
      wait_drain(2000);
    end

    // East downstream stops returning credits
    if (timeout_cnt == 0) begin
      test_name = "back_pressure";
      hold_east = 1'b1;
      east_base = rx_cnt[PORT_E];
      repeat (8) queue_flit(PORT_W, MY_X + 1 + int'(next_rand() % 5), int'(next_rand() % 8));
      wait_east(east_base + 2 * VC_DEPTH, 200);
      repeat (20) @(posedge clk);
      assert (rx_cnt[PORT_E] - east_base <= 2 * VC_DEPTH) else begin
        err_cnt++;
        $display("** Error %s: East flits expected at most %0d, actual %0d",
                 test_name, 2 * VC_DEPTH, rx_cnt[PORT_E] - east_base);
      end
      hold_east = 1'b0;
      wait_drain(500);
    end

    if (timeout_cnt == 0) begin
      test_name = "contention";
      flooding = 1'b1;
      for (int s = PORT_N; s <= PORT_W; s++) begin
        repeat (FLOOD_N) queue_flit(s, MY_X, MY_Y);
      end
      wait_drain(1000);
      flooding = 1'b0;
    end

    report_and_finish();
  end

endmodule

`default_nettype wire

// File: project.f
design/router_pkg.sv
design/sa_if.sv
design/credit_if.sv
design/vc_input_port.sv
design/switch_allocator.sv
design/output_vc_credits.sv
design/switch_traversal.sv
design/vc_router.sv
bench/tb_vc_router.sv

// File: Makefile
# Verilator build and run for the VC router testbench
# make        build, run and decide pass or fail from sim.log
# make lint   lint the RTL top level
# make clean  remove build output and log

TOP = tb_vc_router

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	@grep -qx "sim passed" sim.log

lint:
	verilator --lint-only -Wall -f project.f --top-module vc_router

clean:
	rm -rf obj_dir sim.log
